// ==== hw/dallanma_paketi.sv ====
package dallanma_paketi;

    localparam int XLEN = 32;

    // Dallanma turu kodlari
    typedef logic [2:0] dal_tur_t;

    localparam dal_tur_t BRA_BEQ  = 3'b000;
    localparam dal_tur_t BRA_BNE  = 3'b001;
    localparam dal_tur_t BRA_BLT  = 3'b010;
    localparam dal_tur_t BRA_BGE  = 3'b011;
    localparam dal_tur_t BRA_BLTU = 3'b100;
    localparam dal_tur_t BRA_BGEU = 3'b101;

    // Ongorucu tablo boyutu
    localparam int ONGORU_SATIR  = 16;
    localparam int ONGORU_INDEKS = 4;
    localparam logic [1:0] SAYAC_ZAYIF_ALMAZ = 2'b01;

    localparam logic [6:0] OPC_BRANCH     = 7'b1100011;
    localparam logic [2:0] CB_FUNCT3_BEQZ = 3'b110;
    localparam logic [2:0] CB_FUNCT3_BNEZ = 3'b111;
    localparam logic [1:0] CB_OP          = 2'b01;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_tipi_t;

    // Sikistirilmis CB bicimi, ust yarim kelime kullanilmaz
    typedef struct packed {
        logic [15:0] bos;
        logic [2:0]  funct3;
        logic        off8;
        logic [1:0]  off4_3;
        logic [2:0]  rs1_k;
        logic [1:0]  off7_6;
        logic [1:0]  off2_1;
        logic        off5;
        logic [1:0]  op;
    } cb_tipi_t;

    typedef union packed {
        b_tipi_t  b_tipi;
        cb_tipi_t cb_tipi;
    } buyruk_t;

endpackage

// ==== hw/dallanma_cozucu.sv ====
`timescale 1ns/1ps

module dallanma_cozucu (
    input  dallanma_paketi::buyruk_t          buyruk_i,
    input  logic                              gecerli_i,
    output dallanma_paketi::dal_tur_t         dal_buy_turu_o,
    output logic [dallanma_paketi::XLEN-1:0]  br_o,
    output logic                              sikistirilmis_mi_o,
    output logic                              sifir_karsilastir_o,
    output logic                              cozum_gecerli_o
);
    import dallanma_paketi::*;

    logic yasal;

    // Alt iki bit 11 degilse 16 bitlik buyruk
    assign sikistirilmis_mi_o = (buyruk_i.b_tipi.opcode[1:0] != 2'b11);

    always_comb begin
        dal_buy_turu_o      = BRA_BEQ;
        br_o                = '0;
        sifir_karsilastir_o = 1'b0;
        yasal               = 1'b0;
        if (!sikistirilmis_mi_o) begin
            if (buyruk_i.b_tipi.opcode == OPC_BRANCH) begin
                yasal = 1'b1;
                case (buyruk_i.b_tipi.funct3)
                    3'b000:  dal_buy_turu_o = BRA_BEQ;
                    3'b001:  dal_buy_turu_o = BRA_BNE;
                    3'b100:  dal_buy_turu_o = BRA_BLT;
                    3'b101:  dal_buy_turu_o = BRA_BGE;
                    3'b110:  dal_buy_turu_o = BRA_BLTU;
                    3'b111:  dal_buy_turu_o = BRA_BGEU;
                    default: yasal = 1'b0; // 010 ve 011 tanimsiz
                endcase
                br_o = {{(XLEN-13){buyruk_i.b_tipi.imm12}}, buyruk_i.b_tipi.imm12,
                        buyruk_i.b_tipi.imm11, buyruk_i.b_tipi.imm10_5,
                        buyruk_i.b_tipi.imm4_1, 1'b0};
            end
        end else if (buyruk_i.cb_tipi.op == CB_OP &&
                     (buyruk_i.cb_tipi.funct3 == CB_FUNCT3_BEQZ ||
                      buyruk_i.cb_tipi.funct3 == CB_FUNCT3_BNEZ)) begin
            yasal               = 1'b1;
            sifir_karsilastir_o = 1'b1; // rs2 yerine sifir
            dal_buy_turu_o      = buyruk_i.cb_tipi.funct3[0] ? BRA_BNE : BRA_BEQ;
            br_o = {{(XLEN-9){buyruk_i.cb_tipi.off8}}, buyruk_i.cb_tipi.off8,
                    buyruk_i.cb_tipi.off7_6, buyruk_i.cb_tipi.off5,
                    buyruk_i.cb_tipi.off4_3, buyruk_i.cb_tipi.off2_1, 1'b0};
        end
    end

    assign cozum_gecerli_o = yasal; // Yalnizca kodlamanin yasalligi

    // Sifirla karsilastirma sadece CB bicimindeki dallanmalarda
    always_comb begin
        if (gecerli_i) begin
            assert (!sifir_karsilastir_o || sikistirilmis_mi_o)
                else $error("sifir_karsilastir_o sikistirilmis olmayan buyrukta");
        end
    end

endmodule

// ==== hw/karsilastirici.sv ====
`timescale 1ns/1ps

module karsilastirici (
    input  logic [dallanma_paketi::XLEN-1:0] rs1_deger_i,
    input  logic [dallanma_paketi::XLEN-1:0] rs2_deger_i,
    input  logic                             sifir_karsilastir_i,
    output logic                             esit_mi_o,
    output logic                             buyuk_mu_o,
    output logic                             buyuk_mu_unsigned_o
);
    import dallanma_paketi::*;

    logic [XLEN-1:0] ikinci_islenen;

    // C.BEQZ ve C.BNEZ icin ikinci islenen sifir
    assign ikinci_islenen = sifir_karsilastir_i ? '0 : rs2_deger_i;

    assign esit_mi_o = (rs1_deger_i == ikinci_islenen);

    // Kesin buyukluk, esitlik ayri cikista
    assign buyuk_mu_o          = ($signed(rs1_deger_i) > $signed(ikinci_islenen));
    assign buyuk_mu_unsigned_o = (rs1_deger_i > ikinci_islenen);

endmodule

// ==== hw/dallanma_birimi.sv ====
`timescale 1ns/1ps

module dallanma_birimi (
    input  logic                             rst_i,
    input  logic                             durdur_i,
    input  logic                             blok_aktif_i,
    input  dallanma_paketi::dal_tur_t        dal_buy_turu_i,
    input  logic                             dallanma_ongorusu_i,
    input  logic                             esit_mi_i,
    input  logic                             buyuk_mu_i,
    input  logic                             buyuk_mu_i_unsigned,
    input  logic [dallanma_paketi::XLEN-1:0] ps_i,
    input  logic [dallanma_paketi::XLEN-1:0] br_i,
    input  logic                             sikistirilmis_mi_i,
    output logic                             guncelle_gecerli_o,
    output logic                             guncelle_atladi_o,
    output logic                             dallanma_hata_o,
    output logic [dallanma_paketi::XLEN-1:0] guncelle_hedef_adresi_o,
    output logic [dallanma_paketi::XLEN-1:0] guncelle_ps_o
);
    import dallanma_paketi::*;

    logic            kosul;
    logic            tur_gecerli;
    logic [XLEN-1:0] hedef_adres;
    logic [XLEN-1:0] sirali_adres;

    always_comb begin
        kosul       = 1'b0;
        tur_gecerli = 1'b1;
        case (dal_buy_turu_i)
            BRA_BEQ:  kosul = esit_mi_i;
            BRA_BNE:  kosul = !esit_mi_i;
            BRA_BLT:  kosul = !(buyuk_mu_i || esit_mi_i); // Ne buyuk ne esit
            BRA_BGE:  kosul = buyuk_mu_i || esit_mi_i;
            BRA_BLTU: kosul = !(buyuk_mu_i_unsigned || esit_mi_i);
            BRA_BGEU: kosul = buyuk_mu_i_unsigned || esit_mi_i;
            default: begin
                tur_gecerli = 1'b0; // 110 ve 111 gecersiz
            end
        endcase
    end

    // Atlanmazsa bir sonraki buyruk
    assign sirali_adres = ps_i + (sikistirilmis_mi_i ? XLEN'(2) : XLEN'(4));
    assign hedef_adres  = ps_i + br_i;

    assign guncelle_gecerli_o = rst_i && blok_aktif_i && !durdur_i && tur_gecerli;
    assign guncelle_atladi_o  = blok_aktif_i && tur_gecerli && kosul;

    // Ongoru ile sonuc farkliysa yonlendirme gerekli
    assign dallanma_hata_o = guncelle_gecerli_o &&
                             (dallanma_ongorusu_i != guncelle_atladi_o);

    assign guncelle_hedef_adresi_o = guncelle_atladi_o ? hedef_adres : sirali_adres;
    assign guncelle_ps_o           = ps_i; // Boru hattinda tasinan ps

    always_comb begin
        assert (!dallanma_hata_o || guncelle_gecerli_o)
            else $error("dallanma_hata_o gecersiz guncellemede");
        assert (!guncelle_gecerli_o || !durdur_i)
            else $error("guncelle_gecerli_o durdur sirasinda");
    end

endmodule

// ==== hw/dallanma_ongorucu.sv ====
`timescale 1ns/1ps

module dallanma_ongorucu (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic [dallanma_paketi::XLEN-1:0] ps_i,
    input  logic                             guncelle_gecerli_i,
    input  logic                             guncelle_atladi_i,
    output logic                             ongoru_o
);
    import dallanma_paketi::*;

    logic [1:0]               sayac_r [ONGORU_SATIR];
    logic [ONGORU_INDEKS-1:0] indeks;
    logic [1:0]               secili_sayac;

    // Bit 0 her zaman sifir, indeks bit 1'den baslar
    assign indeks       = ps_i[ONGORU_INDEKS:1];
    assign secili_sayac = sayac_r[indeks];
    assign ongoru_o     = secili_sayac[1]; // 1x ise atlar

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < ONGORU_SATIR; i++) begin
                sayac_r[i] <= SAYAC_ZAYIF_ALMAZ;
            end
        end else if (guncelle_gecerli_i) begin
            if (guncelle_atladi_i) begin
                // 11'de doyar
                if (secili_sayac != 2'b11) begin
                    sayac_r[indeks] <= secili_sayac + 2'd1;
                end
            end else if (secili_sayac != 2'b00) begin
                sayac_r[indeks] <= secili_sayac - 2'd1;
            end
        end
    end

    // Cozum birimi reset sirasinda guncelleme uretmemeli
    a_reset_guncelleme_yok: assert property (
        @(posedge clk_i) !rst_i |-> !guncelle_gecerli_i
    ) else $error("reset sirasinda ongorucu guncellemesi");

endmodule

// ==== hw/dallanma_yurutme.sv ====
`timescale 1ns/1ps

module dallanma_yurutme (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             gecerli_i,
    input  logic                             durdur_i,
    input  dallanma_paketi::buyruk_t         buyruk_i,
    input  logic [dallanma_paketi::XLEN-1:0] ps_i,
    input  logic [dallanma_paketi::XLEN-1:0] rs1_deger_i,
    input  logic [dallanma_paketi::XLEN-1:0] rs2_deger_i,
    output logic                             guncelle_gecerli_o,
    output logic                             guncelle_atladi_o,
    output logic                             dallanma_hata_o,
    output logic [dallanma_paketi::XLEN-1:0] guncelle_hedef_adresi_o,
    output logic [dallanma_paketi::XLEN-1:0] guncelle_ps_o,
    output logic                             ongoru_o
);
    import dallanma_paketi::*;

    dal_tur_t        dal_buy_turu;
    logic [XLEN-1:0] br;
    logic            sikistirilmis_mi;
    logic            sifir_karsilastir;
    logic            cozum_gecerli;
    logic            esit_mi;
    logic            buyuk_mu;
    logic            buyuk_mu_unsigned;
    logic            dallanma_ongorusu;
    logic            blok_aktif;

    // Gecerli ve yasal dallanma
    assign blok_aktif = gecerli_i & cozum_gecerli;
    assign ongoru_o   = dallanma_ongorusu;

    dallanma_cozucu u_cozucu (
        .buyruk_i            (buyruk_i),
        .gecerli_i           (gecerli_i),
        .dal_buy_turu_o      (dal_buy_turu),
        .br_o                (br),
        .sikistirilmis_mi_o  (sikistirilmis_mi),
        .sifir_karsilastir_o (sifir_karsilastir),
        .cozum_gecerli_o     (cozum_gecerli)
    );

    karsilastirici u_karsilastirici (
        .rs1_deger_i         (rs1_deger_i),
        .rs2_deger_i         (rs2_deger_i),
        .sifir_karsilastir_i (sifir_karsilastir),
        .esit_mi_o           (esit_mi),
        .buyuk_mu_o          (buyuk_mu),
        .buyuk_mu_unsigned_o (buyuk_mu_unsigned)
    );

    dallanma_birimi u_birim (
        .rst_i                   (rst_i),
        .durdur_i                (durdur_i),
        .blok_aktif_i            (blok_aktif),
        .dal_buy_turu_i          (dal_buy_turu),
        .dallanma_ongorusu_i     (dallanma_ongorusu),
        .esit_mi_i               (esit_mi),
        .buyuk_mu_i              (buyuk_mu),
        .buyuk_mu_i_unsigned     (buyuk_mu_unsigned),
        .ps_i                    (ps_i),
        .br_i                    (br),
        .sikistirilmis_mi_i      (sikistirilmis_mi),
        .guncelle_gecerli_o      (guncelle_gecerli_o),
        .guncelle_atladi_o       (guncelle_atladi_o),
        .dallanma_hata_o         (dallanma_hata_o),
        .guncelle_hedef_adresi_o (guncelle_hedef_adresi_o),
        .guncelle_ps_o           (guncelle_ps_o)
    );

    // Ayni cevrimde kendi ps'i ile bakilir
    dallanma_ongorucu u_ongorucu (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .ps_i               (ps_i),
        .guncelle_gecerli_i (guncelle_gecerli_o),
        .guncelle_atladi_i  (guncelle_atladi_o),
        .ongoru_o           (dallanma_ongorusu)
    );

endmodule

// ==== sim/tb_dallanma_yurutme.sv ====
`timescale 1ns/1ps

module tb_dallanma_yurutme;

    logic        clk;
    logic        rst;
    logic        gecerli;
    logic        durdur;
    logic [31:0] buyruk;
    logic [31:0] ps;
    logic [31:0] rs1_deger;
    logic [31:0] rs2_deger;
    logic        guncelle_gecerli;
    logic        guncelle_atladi;
    logic        dallanma_hata;
    logic [31:0] guncelle_hedef_adresi;
    logic [31:0] guncelle_ps;
    logic        ongoru;

    logic [31:0] rng_state = 32'd32686;
    logic [1:0]  model_ctr [16]; // Ongorucu tablosunun kopyasi
    logic [31:0] pair_a [4];
    logic [31:0] pair_b [4];
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    dallanma_yurutme UUT (
        .clk_i                   (clk),
        .rst_i                   (rst),
        .gecerli_i               (gecerli),
        .durdur_i                (durdur),
        .buyruk_i                (buyruk),
        .ps_i                    (ps),
        .rs1_deger_i             (rs1_deger),
        .rs2_deger_i             (rs2_deger),
        .guncelle_gecerli_o      (guncelle_gecerli),
        .guncelle_atladi_o       (guncelle_atladi),
        .dallanma_hata_o         (dallanma_hata),
        .guncelle_hedef_adresi_o (guncelle_hedef_adresi),
        .guncelle_ps_o           (guncelle_ps),
        .ongoru_o                (ongoru)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi = rng_state;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], rng_state[31:16]}; // Ust bitler daha iyi dagilir
    endfunction

    function automatic logic [31:0] make_btype(input logic [2:0] f3, input logic [12:0] imm,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] make_cb(input logic bnez, input logic [8:0] off,
                                            input logic [2:0] rs1k);
        return {16'h0000, 2'b11, bnez, off[8], off[4:3], rs1k, off[7:6], off[2:1], off[5],
                2'b01};
    endfunction

    // Sonuc bicimi {yasal, atladi, hedef}
    function automatic logic [33:0] reference_resolve(input logic valid, input logic [31:0] w,
                                                      input logic [31:0] pc,
                                                      input logic [31:0] a,
                                                      input logic [31:0] b);
        logic        legal;
        logic        cond;
        logic        taken;
        logic [31:0] imm;
        logic [31:0] step_len;
        legal = 1'b0;
        cond  = 1'b0;
        if (w[1:0] == 2'b11) begin
            step_len = 32'd4;
            imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            if (w[6:0] == 7'b1100011) begin
                legal = 1'b1;
                case (w[14:12])
                    3'b000:  cond = (a == b);
                    3'b001:  cond = (a != b);
                    3'b100:  cond = ($signed(a) < $signed(b));
                    3'b101:  cond = ($signed(a) >= $signed(b));
                    3'b110:  cond = (a < b);
                    3'b111:  cond = (a >= b);
                    default: legal = 1'b0;
                endcase
            end
        end else begin
            step_len = 32'd2;
            imm = {{23{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
            if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
                legal = 1'b1;
                cond  = w[13] ? (a != 32'd0) : (a == 32'd0); // rs2 yok sayilir
            end
        end
        taken = valid && legal && cond;
        return {legal, taken, taken ? pc + imm : pc + step_len};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_branch(input logic valid, input logic stall, input logic [31:0] w,
                                input logic [31:0] pc, input logic [31:0] a,
                                input logic [31:0] b);
        gecerli   = valid;
        durdur    = stall;
        buyruk    = w;
        ps        = pc;
        rs1_deger = a;
        rs2_deger = b;
    endtask

    // Kenardan hemen once ornekle, modeli guncelle
    initial begin
        logic [33:0] ref_sonuc;
        logic [3:0]  idx;
        logic        exp_pred;
        logic        exp_valid;
        logic        exp_taken;
        forever begin
            @(posedge clk);
            #3;
            if (!rst) begin
                for (int i = 0; i < 16; i++) begin
                    model_ctr[i] = 2'b01;
                end
                // Reset sirasinda guncelleme ve hata yok
                check_value("guncelle_gecerli_o", 32'(guncelle_gecerli), 32'd0);
                check_value("dallanma_hata_o", 32'(dallanma_hata), 32'd0);
            end else begin
                ref_sonuc = reference_resolve(gecerli, buyruk, ps, rs1_deger, rs2_deger);
                idx       = ps[4:1];
                exp_pred  = model_ctr[idx][1];
                exp_valid = gecerli && !durdur && ref_sonuc[33];
                exp_taken = ref_sonuc[32];
                check_value("ongoru_o", 32'(ongoru), 32'(exp_pred));
                check_value("guncelle_gecerli_o", 32'(guncelle_gecerli), 32'(exp_valid));
                check_value("guncelle_atladi_o", 32'(guncelle_atladi), 32'(exp_taken));
                check_value("dallanma_hata_o", 32'(dallanma_hata),
                            32'(exp_valid && (exp_pred != exp_taken)));
                check_value("guncelle_hedef_adresi_o", guncelle_hedef_adresi, ref_sonuc[31:0]);
                check_value("guncelle_ps_o", guncelle_ps, ps);
                if (exp_valid) begin
                    if (exp_taken && model_ctr[idx] != 2'b11) begin
                        model_ctr[idx] = model_ctr[idx] + 2'd1;
                    end else if (!exp_taken && model_ctr[idx] != 2'b00) begin
                        model_ctr[idx] = model_ctr[idx] - 2'd1;
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        logic [31:0] pc;
        int          tries;
        rst = 1'b0;
        // Reset boyunca gecerli ve atlayan bir dallanma
        drive_branch(1'b1, 1'b0, make_btype(3'b000, 13'h0040, 5'd1, 5'd2), 32'h0000_0108,
                     32'd7, 32'd7);
        pair_a[0] = 32'h8000_0000;
        pair_b[0] = 32'h0000_0001;
        pair_a[1] = 32'h0000_0001;
        pair_b[1] = 32'h8000_0000;
        pair_a[2] = 32'h0000_0005;
        pair_b[2] = 32'h0000_0005;
        pair_a[3] = 32'hFFFF_FFFF;
        pair_b[3] = 32'h0000_0000;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        // Resetten sonra her satir almaz
        for (int i = 0; i < 16; i++) begin
            drive_branch(1'b0, 1'b0, 32'h0000_0013, 32'h0000_1000 + 32'(i * 2), 32'd0, 32'd0);
            next_cycle();
        end

        // Alti B-tipi kosul ile isaretli ve isaretsiz fark
        for (int i = 0; i < 8; i++) begin
            if (i == 2 || i == 3) continue;
            for (int k = 0; k < 4; k++) begin
                word = make_btype(i[2:0], k[0] ? 13'h1FF0 : 13'h01F0, 5'd1, 5'd2);
                drive_branch(1'b1, 1'b0, word, 32'h0000_3000, pair_a[k], pair_b[k]);
                next_cycle();
            end
        end

        // C.BEQZ ve C.BNEZ rs2'deki anlamsiz degeri yok sayar
        for (int k = 0; k < 4; k++) begin
            word = make_cb(k[0], k[1] ? 9'h1F8 : 9'h0A6, 3'd2);
            a = k[1] ? 32'd0 : 32'h0000_0010;
            drive_branch(1'b1, 1'b0, word, 32'h0000_3000, a, 32'hDEAD_BEEF);
            next_cycle();
        end

        // Satir 4 once 00'a iner, sonra iki atlayan guncelleme gorur
        drive_branch(1'b1, 1'b0, make_btype(3'b000, 13'h0040, 5'd1, 5'd2), 32'h0000_0108,
                     32'd1, 32'd2);
        next_cycle();
        drive_branch(1'b1, 1'b0, make_btype(3'b000, 13'h0040, 5'd1, 5'd2), 32'h0000_0108,
                     32'd7, 32'd7);
        tries = 0;
        while (ongoru !== 1'b1 && tries < 8) begin
            next_cycle();
            tries++;
        end
        if (tries >= 8) begin
            timeouts++;
            $display("Timeout: prediction never turned to taken on repeated taken branches");
        end else begin
            check_value("taken_updates", 32'(tries), 32'd2);
        end

        // Durdurma ve yasadisi buyruklar tabloyu degistirmez
        drive_branch(1'b1, 1'b1, make_btype(3'b000, 13'h0040, 5'd1, 5'd2), 32'h0000_0108,
                     32'd1, 32'd2);
        next_cycle();
        next_cycle();
        drive_branch(1'b1, 1'b0, make_btype(3'b010, 13'h0040, 5'd1, 5'd2), 32'h0000_0108,
                     32'd1, 32'd2);
        next_cycle();
        word = make_btype(3'b000, 13'h0040, 5'd1, 5'd2);
        word[6:0] = 7'b0010011; // Branch olmayan opcode
        drive_branch(1'b1, 1'b0, word, 32'h0000_0108, 32'd1, 32'd2);
        next_cycle();
        drive_branch(1'b0, 1'b0, word, 32'h0000_0108, 32'd1, 32'd2);
        #1;
        check_value("ongoru_o", 32'(ongoru), 32'd1);

        for (int n = 0; n < 300; n++) begin
            r = lcg_next();
            s = lcg_next();
            a = lcg_next();
            b = lcg_next();
            case (r[4:3])
                2'd0:    b = a;
                2'd1:    b = a ^ 32'h8000_0000; // Yalnizca isaret farkli
                default: b = b;
            endcase
            if (r[6:5] == 2'd0) begin
                a = 32'd0;
            end
            pc = 32'h0000_2000 | {27'd0, r[10:7], 1'b0};
            if (s[7:5] < 3'd5) begin
                word = make_btype(r[13:11], r[26:14], r[31:27], r[4:0]);
            end else if (s[7:5] < 3'd7) begin
                word = make_cb(r[11], r[20:12], r[23:21]);
            end else begin
                word = lcg_next();
            end
            drive_branch(s[2:0] != 3'd0, s[10:8] == 3'd0, word, pc, a, b);
            next_cycle();
        end

        drive_branch(1'b0, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0);
        next_cycle();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/dallanma_paketi.sv
hw/dallanma_cozucu.sv
hw/karsilastirici.sv
hw/dallanma_birimi.sv
hw/dallanma_ongorucu.sv
hw/dallanma_yurutme.sv
sim/tb_dallanma_yurutme.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_dallanma_yurutme \
		-f vlog.f --Mdir obj_dir -o tb_dallanma_yurutme
	@out="$$(./obj_dir/tb_dallanma_yurutme)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
